//--- Bender.yml
package:
  name: fullAlu

sources:
  # packages first, the RTL modules import them
  - files:
      - verilog/aluOpsPkg.sv
      - verilog/operandPkg.sv
      - verilog/operandSelect.sv
      - verilog/aluExecute.sv
      - verilog/conditionCodes.sv
      - verilog/fullAlu.sv

  - target: test
    files:
      - testbench/fullAlu_sva.sv
      - testbench/fullAluTb.sv

//--- src.f
verilog/aluOpsPkg.sv
verilog/operandPkg.sv
verilog/operandSelect.sv
verilog/aluExecute.sv
verilog/conditionCodes.sv
verilog/fullAlu.sv
testbench/fullAlu_sva.sv
testbench/fullAluTb.sv

//--- testbench/fullAluTb.sv
`timescale 1ns/10ps

module fullAluTb
	import aluOpsPkg::*;
	import operandPkg::*;
();

	localparam int clkPeriod = 20;
	localparam int stimDelay = 2;
	localparam int resetCycles = 8;
	localparam int randomCycles = 500;
	localparam int compareTimeout = 10;

	// everything the CPU control lines put on the block in one cycle
	typedef struct packed {
		dataWord regA;
		dataWord regB;
		aluOp    op;
		aluASrc  aSel;
		aluBSrc  bSel;
		argField argA;
		argField argB;
		logic    b5;
		logic    ccLoad;
	} stimVec;

	typedef struct packed {
		dataWord aData;
		dataWord bData;
		dataWord result;
		ccFlags  flags;
	} expectVec;

	logic    clk;
	logic    arstN;
	stimVec  stim;
	dataWord aluResult;
	ccFlags  flags;
	dataWord aluAData;
	dataWord aluBData;

	// flag register as the testbench expects the DUT to hold it
	ccFlags  modelFlags = '0;
	int      seed = 60196;
	int      errorCount = 0;
	int      checkCount = 0;
	int      drivenIdx = 0;
	int      comparedIdx = 0;
	dataWord corners [5] = '{16'h0000, 16'h0001, 16'h7fff, 16'h8000, 16'hffff};

	fullAlu i_fullAlu (
		.clk       (clk),
		.arstN     (arstN),
		.regADout  (stim.regA),
		.regBDout  (stim.regB),
		.aluOpSel  (stim.op),
		.aluASel   (stim.aSel),
		.aluBSel   (stim.bSel),
		.argA      (stim.argA),
		.argB      (stim.argB),
		.b5        (stim.b5),
		.ccLoad    (stim.ccLoad),
		.aluResult (aluResult),
		.flags     (flags),
		.aluAData  (aluAData),
		.aluBData  (aluBData)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	function automatic expectVec computeExpected(input stimVec s, input logic cIn);
		expectVec    e;
		logic [16:0] wide;
		logic [16:0] subtrahend;
		case (s.aSel)
			srcARegA: e.aData = s.regA;
			srcAArg:  e.aData = {12'h000, s.argA};
			srcAImm5: e.aData = {11'h000, s.b5, s.argA};
			default:  e.aData = 16'h0000;
		endcase
		case (s.bSel)
			srcBRegB: e.bData = s.regB;
			srcBArg:  e.bData = {12'h000, s.argB};
			srcBImm8: e.bData = {8'h00, s.argA, s.argB};
			default:  e.bData = 16'h0001;
		endcase
		e.flags.carry = 1'b0;
		// borrow means the unsigned A is below B plus the borrow-in
		subtrahend = {1'b0, e.bData} + {16'h0000, cIn};
		case (s.op)
			opAdd, opAdc, opInc: begin
				if (s.op == opAdd) wide = {1'b0, e.aData} + {1'b0, e.bData};
				else if (s.op == opAdc) wide = {1'b0, e.aData} + {1'b0, e.bData} + {16'h0, cIn};
				else wide = {1'b0, e.aData} + 17'h00001;
				e.result = wide[15:0];
				e.flags.carry = wide[16];
			end
			opSub: begin
				e.result = e.aData - e.bData;
				e.flags.carry = (e.aData < e.bData);
			end
			opSbc: begin
				e.result = e.aData - e.bData - {15'h0000, cIn};
				e.flags.carry = ({1'b0, e.aData} < subtrahend);
			end
			opDec: begin
				e.result = e.aData - 16'h0001;
				e.flags.carry = (e.aData == 16'h0000);
			end
			opAnd: e.result = e.aData & e.bData;
			opOr: e.result = e.aData | e.bData;
			opXor: e.result = e.aData ^ e.bData;
			opNot: e.result = ~e.aData;
			opShl, opRol: begin
				e.result = (s.op == opShl) ? e.aData << 1 : {e.aData[14:0], e.aData[15]};
				e.flags.carry = e.aData[15];
			end
			opShr, opRor: begin
				e.result = (s.op == opShr) ? e.aData >> 1 : {e.aData[0], e.aData[15:1]};
				e.flags.carry = e.aData[0];
			end
			opPassB: e.result = e.bData;
			default: e.result = {e.aData[7:0], e.aData[15:8]};
		endcase
		e.flags.zero = (e.result == 16'h0000);
		e.flags.sign = e.result[15];
		e.flags.parity = ^e.result;
		return e;
	endfunction

	// outputs settle well before the falling edge, so the checks sample there
	initial begin : compareProc
		expectVec expected;
		// nothing is driven before the first rising edge
		@(posedge clk);
		forever begin
			@(negedge clk);
			expected = computeExpected(stim, modelFlags.carry);
			checkCount++;
			if (aluAData !== expected.aData) begin
				errorCount++;
				$display("Error: aluAData expected %h actual %h", expected.aData, aluAData);
			end
			if (aluBData !== expected.bData) begin
				errorCount++;
				$display("Error: aluBData expected %h actual %h", expected.bData, aluBData);
			end
			if (aluResult !== expected.result) begin
				errorCount++;
				$display("Error: aluResult expected %h actual %h", expected.result, aluResult);
			end
			if (flags !== modelFlags) begin
				errorCount++;
				$display("Error: flags expected %h actual %h", modelFlags, flags);
			end
			if (!arstN) modelFlags = '0;
			else if (stim.ccLoad) modelFlags = expected.flags;
			comparedIdx = drivenIdx;
		end
	end

	task automatic applyInputs(input stimVec s);
		@(posedge clk);
		#stimDelay;
		stim = s;
		drivenIdx++;
	endtask

	function automatic stimVec randomInputs();
		stimVec      s;
		logic [31:0] r;
		s.regA = $random(seed);
		s.regB = $random(seed);
		r = $random(seed);
		s.op = aluOp'(r[3:0]);
		s.aSel = aluASrc'(r[5:4]);
		s.bSel = aluBSrc'(r[7:6]);
		s.argA = r[11:8];
		s.argB = r[15:12];
		s.b5 = r[16];
		s.ccLoad = r[17];
		return s;
	endfunction

	// low word with add or sub, high word with adc or sbc on the latched carry
	task automatic chainPair(input logic [31:0] x, input logic [31:0] y, input logic isSub);
		stimVec      s;
		dataWord     loWord;
		logic [31:0] expect32;
		s = '0;
		s.ccLoad = 1'b1;
		s.regA = x[15:0];
		s.regB = y[15:0];
		s.op = isSub ? opSub : opAdd;
		applyInputs(s);
		@(negedge clk);
		loWord = aluResult;
		s.regA = x[31:16];
		s.regB = y[31:16];
		s.op = isSub ? opSbc : opAdc;
		applyInputs(s);
		@(negedge clk);
		expect32 = isSub ? x - y : x + y;
		checkCount++;
		if ({aluResult, loWord} !== expect32) begin
			errorCount++;
			$display("Error: chained aluResult expected %h actual %h", expect32, {aluResult, loWord});
		end
	endtask

	task automatic waitCompared();
		int cycles;
		cycles = 0;
		while (comparedIdx != drivenIdx && cycles < compareTimeout) begin
			@(posedge clk);
			cycles++;
		end
		if (comparedIdx != drivenIdx) begin
			errorCount++;
			$display("the compare process fell behind the stimulus and timed out");
		end
	endtask

	initial begin
		stimVec s;
		arstN = 1'b0;
		stim = '0;
		// aluResult must follow the inputs even while the flags are held clear
		for (int i = 0; i < resetCycles; i++) begin
			s = randomInputs();
			s.ccLoad = 1'b1;
			applyInputs(s);
		end
		arstN = 1'b1;
		for (int a = 0; a < 4; a++) begin
			for (int b = 0; b < 4; b++) begin
				for (int k = 0; k < 4; k++) begin
					s = randomInputs();
					s.aSel = aluASrc'(a[1:0]);
					s.bSel = aluBSrc'(b[1:0]);
					applyInputs(s);
				end
			end
		end
		for (int op = 0; op < 16; op++) begin
			for (int i = 0; i < 5; i++) begin
				for (int j = 0; j < 5; j++) begin
					s = '0;
					s.op = aluOp'(op[3:0]);
					s.regA = corners[i];
					s.regB = corners[j];
					s.ccLoad = 1'b1;
					applyInputs(s);
				end
			end
		end
		s = '0;
		s.op = opSub;
		s.regB = 16'h0001;
		s.ccLoad = 1'b1;
		applyInputs(s);
		for (int i = 0; i < 4; i++) begin
			s = randomInputs();
			s.ccLoad = 1'b0;
			applyInputs(s);
		end
		s.ccLoad = 1'b1;
		applyInputs(s);
		chainPair(32'h0001_ffff, 32'h0000_0001, 1'b0);
		chainPair(32'h1234_8000, 32'h0fff_8000, 1'b0);
		chainPair(32'h0001_0000, 32'h0000_0001, 1'b1);
		chainPair(32'h8000_0000, 32'h7fff_ffff, 1'b1);
		chainPair(32'h0000_0000, 32'h0000_0001, 1'b1);
		for (int i = 0; i < randomCycles; i++) begin
			applyInputs(randomInputs());
		end
		// one idle cycle so the last random load reaches the flag compare
		s = '0;
		applyInputs(s);
		waitCompared();
		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- testbench/fullAlu_sva.sv
`timescale 1ns/10ps

module fullAluSva
	import aluOpsPkg::*;
(
	input logic   clk,
	input logic   arstN,
	input logic   ccLoad,
	input ccFlags nextFlags,
	input ccFlags flags
);

	// the register is cleared for as long as reset is held
	flagsClearInReset: assert property (
		@(posedge clk) !arstN |-> (flags == '0)
	) else $error("flags are not zero while arstN is low");

	// no load strobe, no change
	flagsHeld: assert property (
		@(posedge clk) disable iff (!arstN)
		!ccLoad |=> $stable(flags)
	) else $error("flags changed across an edge without ccLoad");

	// a load captures what the execute stage offered in that cycle
	flagsLoaded: assert property (
		@(posedge clk) disable iff (!arstN)
		ccLoad |=> (flags == $past(nextFlags))
	) else $error("flags differ from the loaded nextFlags");

endmodule

bind conditionCodes fullAluSva i_fullAluSva (
	.clk       (clk),
	.arstN     (arstN),
	.ccLoad    (ccLoad),
	.nextFlags (nextFlags),
	.flags     (flags)
);

//--- verilog/aluExecute.sv
`timescale 1ns/10ps

module aluExecute
	import aluOpsPkg::*;
(
	input  dataWord aluAData,
	input  dataWord aluBData,
	input  aluOp    aluOpSel,
	input  logic    carryIn,
	output dataWord aluResult,
	output ccFlags  nextFlags
);

	dataWord addB;
	logic    addCin;
	logic    addSub;
	sumWord  sum;
	logic    addCarry;
	logic    opCarry;

	// subtraction runs on the same adder as A plus the inverted B plus one
	always_comb begin
		addB   = aluBData;
		addCin = 1'b0;
		addSub = 1'b0;
		case (aluOpSel)
			opAdc: begin
				addCin = carryIn;
			end
			opSub: begin
				addB   = ~aluBData;
				addCin = 1'b1;
				addSub = 1'b1;
			end
			opSbc: begin
				// the latched carry is a borrow here, so it removes the plus one
				addB   = ~aluBData;
				addCin = ~carryIn;
				addSub = 1'b1;
			end
			opInc: begin
				addB   = '0;
				addCin = 1'b1;
			end
			opDec: begin
				addB   = ~dataWord'(1);
				addCin = 1'b1;
				addSub = 1'b1;
			end
			default: begin
				addB   = aluBData;
				addCin = 1'b0;
				addSub = 1'b0;
			end
		endcase
	end

	assign sum = {1'b0, aluAData} + {1'b0, addB} + sumWord'(addCin);

	// a missing carry out of a subtraction means A was below B plus the borrow
	assign addCarry = addSub ? ~sum[dataWidth] : sum[dataWidth];

	always_comb begin
		case (aluOpSel)
			opAdd, opAdc, opSub, opSbc, opInc, opDec: begin
				aluResult = sum[dataWidth-1:0];
			end
			opAnd: begin
				aluResult = aluAData & aluBData;
			end
			opOr: begin
				aluResult = aluAData | aluBData;
			end
			opXor: begin
				aluResult = aluAData ^ aluBData;
			end
			opNot: begin
				aluResult = ~aluAData;
			end
			opShl: begin
				aluResult = {aluAData[dataWidth-2:0], 1'b0};
			end
			opShr: begin
				aluResult = {1'b0, aluAData[dataWidth-1:1]};
			end
			opRol: begin
				aluResult = {aluAData[dataWidth-2:0], aluAData[dataWidth-1]};
			end
			opRor: begin
				aluResult = {aluAData[0], aluAData[dataWidth-1:1]};
			end
			opPassB: begin
				aluResult = aluBData;
			end
			opSwapBytes: begin
				aluResult = {aluAData[7:0], aluAData[15:8]};
			end
			default: begin
				aluResult = '0;
			end
		endcase
	end

	// shifts and rotates report the bit that falls off the word
	always_comb begin
		case (aluOpSel)
			opAdd, opAdc, opSub, opSbc, opInc, opDec: begin
				opCarry = addCarry;
			end
			opShl, opRol: begin
				opCarry = aluAData[dataWidth-1];
			end
			opShr, opRor: begin
				opCarry = aluAData[0];
			end
			default: begin
				opCarry = 1'b0;
			end
		endcase
	end

	assign nextFlags.zero   = (aluResult == '0);
	assign nextFlags.carry  = opCarry;
	assign nextFlags.sign   = aluResult[dataWidth-1];
	assign nextFlags.parity = ^aluResult;

endmodule

//--- verilog/aluOpsPkg.sv
package aluOpsPkg;

	// the whole datapath is one machine word wide
	localparam int dataWidth = 16;

	typedef logic [dataWidth-1:0] dataWord;

	// adder result with the carry out of the top bit in front
	typedef logic [dataWidth:0] sumWord;

	// operation select from the instruction decoder
	typedef enum logic [3:0] {
		opAdd       = 4'h0,
		// add with the latched carry
		opAdc       = 4'h1,
		opSub       = 4'h2,
		// subtract with the latched borrow
		opSbc       = 4'h3,
		opAnd       = 4'h4,
		opOr        = 4'h5,
		opXor       = 4'h6,
		// inverts A and ignores B
		opNot       = 4'h7,
		opShl       = 4'h8,
		opShr       = 4'h9,
		// rotates go around the word only, not through the carry
		opRol       = 4'ha,
		opRor       = 4'hb,
		opPassB     = 4'hc,
		opSwapBytes = 4'hd,
		opInc       = 4'he,
		opDec       = 4'hf
	} aluOp;

	// condition codes as seen by the branch logic
	typedef struct packed {
		logic zero;
		// carry out on add, borrow on subtract, shifted-out bit on shifts
		logic carry;
		logic sign;
		// set for an odd number of ones
		logic parity;
	} ccFlags;

endpackage

//--- verilog/conditionCodes.sv
`timescale 1ns/10ps

module conditionCodes
	import aluOpsPkg::*;
(
	input  logic   clk,
	input  logic   arstN,
	input  logic   ccLoad,
	input  ccFlags nextFlags,
	output ccFlags flags
);

	// the decoder raises ccLoad only for instructions that update the flags,
	// so loads and moves leave the last comparison result in place
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			flags <= '0;
		end else if (ccLoad) begin
			flags <= nextFlags;
		end
	end

endmodule

//--- verilog/fullAlu.sv
`timescale 1ns/10ps

module fullAlu
	import aluOpsPkg::*;
	import operandPkg::*;
(
	input  logic    clk,
	input  logic    arstN,
	input  dataWord regADout,
	input  dataWord regBDout,
	input  aluOp    aluOpSel,
	input  aluASrc  aluASel,
	input  aluBSrc  aluBSel,
	input  argField argA,
	input  argField argB,
	input  logic    b5,
	input  logic    ccLoad,
	output dataWord aluResult,
	output ccFlags  flags,
	output dataWord aluAData,
	output dataWord aluBData
);

	ccFlags nextFlags;

	operandSelect i_operandSelect (
		.regADout (regADout),
		.regBDout (regBDout),
		.aluASel  (aluASel),
		.aluBSel  (aluBSel),
		.argA     (argA),
		.argB     (argB),
		.b5       (b5),
		.aluAData (aluAData),
		.aluBData (aluBData)
	);

	// the latched carry feeds back so adc and sbc can chain words
	aluExecute i_aluExecute (
		.aluAData  (aluAData),
		.aluBData  (aluBData),
		.aluOpSel  (aluOpSel),
		.carryIn   (flags.carry),
		.aluResult (aluResult),
		.nextFlags (nextFlags)
	);

	conditionCodes i_conditionCodes (
		.clk       (clk),
		.arstN     (arstN),
		.ccLoad    (ccLoad),
		.nextFlags (nextFlags),
		.flags     (flags)
	);

endmodule

//--- verilog/operandPkg.sv
package operandPkg;

	localparam int argWidth = 4;

	// one argument nibble of the instruction word
	typedef logic [argWidth-1:0] argField;

	// sources for the A side of the ALU
	typedef enum logic [1:0] {
		srcARegA = 2'b00,
		// argA nibble, zero-extended
		srcAArg  = 2'b01,
		// b5 on top of the argA nibble
		srcAImm5 = 2'b10,
		srcAZero = 2'b11
	} aluASrc;

	// sources for the B side of the ALU
	typedef enum logic [1:0] {
		srcBRegB = 2'b00,
		// argB nibble, zero-extended
		srcBArg  = 2'b01,
		// argA is the high nibble and argB the low one
		srcBImm8 = 2'b10,
		srcBOne  = 2'b11
	} aluBSrc;

endpackage

//--- verilog/operandSelect.sv
`timescale 1ns/10ps

module operandSelect
	import aluOpsPkg::*;
	import operandPkg::*;
(
	input  dataWord regADout,
	input  dataWord regBDout,
	input  aluASrc  aluASel,
	input  aluBSrc  aluBSel,
	input  argField argA,
	input  argField argB,
	input  logic    b5,
	output dataWord aluAData,
	output dataWord aluBData
);

	dataWord argAWord;
	dataWord imm5Word;
	dataWord argBWord;
	dataWord imm8Word;

	// immediates are always unsigned, the upper bits come in as zero
	assign argAWord = dataWord'(argA);
	assign imm5Word = dataWord'({b5, argA});
	assign argBWord = dataWord'(argB);
	// a byte immediate is spread over both argument fields
	assign imm8Word = dataWord'({argA, argB});

	always_comb begin
		case (aluASel)
			srcARegA: begin
				aluAData = regADout;
			end
			srcAArg: begin
				aluAData = argAWord;
			end
			srcAImm5: begin
				aluAData = imm5Word;
			end
			default: begin
				aluAData = '0;
			end
		endcase
	end

	always_comb begin
		case (aluBSel)
			srcBRegB: begin
				aluBData = regBDout;
			end
			srcBArg: begin
				aluBData = argBWord;
			end
			srcBImm8: begin
				aluBData = imm8Word;
			end
			default: begin
				// used by the decoder for increments through the B side
				aluBData = dataWord'(1);
			end
		endcase
	end

endmodule
